// ==== soc_config.svh ====
/*
  Build-time constants for the Wishbone SoC harness.
  Base addresses must be aligned to their region length.
  Region lengths are in bytes and the data bus is 32 bits wide.
*/
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// --------------------
// Bus widths
// --------------------
`define SOC_ADDR_WIDTH 32
`define SOC_DATA_WIDTH 32
`define SOC_SEL_WIDTH 4

// --------------------
// Address map
// --------------------
`define SOC_DEBUG_BASE 32'h0000_0000
`define SOC_DEBUG_LEN 32'h0000_1000
`define SOC_ROM_BASE 32'h0001_0000
`define SOC_ROM_LEN 32'h0000_0100
`define SOC_CLINT_BASE 32'h0200_0000
`define SOC_CLINT_LEN 32'h0001_0000
`define SOC_RAM_BASE 32'h8000_0000
`define SOC_RAM_LEN 32'h0000_1000

// Memory depths in words
`define SOC_RAM_WORDS 1024
`define SOC_ROM_WORDS 64

// Boot code runs undisturbed for this many cycles after reset
`define SOC_DEBUG_DELAY_CYCLES 32

`endif

// ==== soc_pkg.sv ====
/*
  Shared types for the SoC harness.
  Widths come from the config header, so change them there.
*/
`default_nettype none

`include "soc_config.svh"

package soc_pkg;

  // --------------------
  // Bus vectors
  // --------------------
  typedef logic [`SOC_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`SOC_DATA_WIDTH-1:0] data_t;
  typedef logic [`SOC_SEL_WIDTH-1:0] sel_t;

  // Timer value spans two bus words
  typedef logic [2*`SOC_DATA_WIDTH-1:0] mtime_t;

  // --------------------
  // Decoder targets
  // --------------------
  typedef enum logic [2:0] {
    TGT_DEBUG,
    TGT_ROM,
    TGT_CLINT,
    TGT_RAM,
    TGT_NONE
  } target_e;

endpackage

`default_nettype wire

// ==== wb_decoder.sv ====
/*
  Wishbone classic address decoder for a single master.
  Only one transaction may be in flight. The master holds the address
  until ack or err, so the returned path is selected by the live address.
  Unmapped addresses answer with err one cycle after the request.
*/
`timescale 1ns/100ps
`default_nettype none

`include "soc_config.svh"

module wb_decoder (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           cyc_i,
  input  logic           stb_i,
  input  soc_pkg::addr_t adr_i,
  input  logic           dbg_ack_i,
  input  logic           rom_ack_i,
  input  logic           rom_err_i,
  input  logic           clint_ack_i,
  input  logic           ram_ack_i,
  input  soc_pkg::data_t dbg_dat_i,
  input  soc_pkg::data_t rom_dat_i,
  input  soc_pkg::data_t clint_dat_i,
  input  soc_pkg::data_t ram_dat_i,
  output logic           dbg_stb_o,
  output logic           rom_stb_o,
  output logic           clint_stb_o,
  output logic           ram_stb_o,
  output soc_pkg::data_t dat_o,
  output logic           ack_o,
  output logic           err_o
);
  import soc_pkg::*;

  target_e tgt;
  logic    req;
  logic    none_err_q;

  // Subtracting first keeps the top of the map from wrapping
  function automatic logic in_region(addr_t adr, addr_t base, addr_t len);
    return (adr >= base) && ((adr - base) < len);
  endfunction

  // --------------------
  // Address decode
  // --------------------
  always_comb begin
    if (in_region(adr_i, `SOC_DEBUG_BASE, `SOC_DEBUG_LEN)) begin
      tgt = TGT_DEBUG;
    end else if (in_region(adr_i, `SOC_ROM_BASE, `SOC_ROM_LEN)) begin
      tgt = TGT_ROM;
    end else if (in_region(adr_i, `SOC_CLINT_BASE, `SOC_CLINT_LEN)) begin
      tgt = TGT_CLINT;
    end else if (in_region(adr_i, `SOC_RAM_BASE, `SOC_RAM_LEN)) begin
      tgt = TGT_RAM;
    end else begin
      tgt = TGT_NONE;
    end
  end

  assign req         = cyc_i & stb_i;
  assign dbg_stb_o   = req & (tgt == TGT_DEBUG);
  assign rom_stb_o   = req & (tgt == TGT_ROM);
  assign clint_stb_o = req & (tgt == TGT_CLINT);
  assign ram_stb_o   = req & (tgt == TGT_RAM);

  // One decode error pulse per unmapped request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      none_err_q <= 1'b0;
    end else begin
      none_err_q <= req & (tgt == TGT_NONE) & ~none_err_q;
    end
  end

  // --------------------
  // Response mux
  // --------------------
  always_comb begin
    dat_o = '0;
    ack_o = 1'b0;
    err_o = 1'b0;
    case (tgt)
      TGT_DEBUG: begin
        dat_o = dbg_dat_i;
        ack_o = dbg_ack_i;
      end
      TGT_ROM: begin
        dat_o = rom_dat_i;
        ack_o = rom_ack_i;
        err_o = rom_err_i;
      end
      TGT_CLINT: begin
        dat_o = clint_dat_i;
        ack_o = clint_ack_i;
      end
      TGT_RAM: begin
        dat_o = ram_dat_i;
        ack_o = ram_ack_i;
      end
      default: begin
        err_o = none_err_q;
      end
    endcase
  end

  // A response from any target must reach the master
  a_resp_routed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dbg_ack_i || rom_ack_i || rom_err_i || clint_ack_i || ram_ack_i || none_err_q)
      |-> (ack_o || err_o));

endmodule

`default_nettype wire

// ==== boot_rom.sv ====
/*
  Boot ROM with a fixed four-word program, remaining words read zero.
  Writes are refused with err. Address bits above the ROM size are ignored.
*/
`timescale 1ns/100ps
`default_nettype none

`include "soc_config.svh"

module boot_rom (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           cyc_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  soc_pkg::addr_t adr_i,
  output soc_pkg::data_t dat_o,
  output logic           ack_o,
  output logic           err_o
);
  import soc_pkg::*;

  localparam int IdxW = $clog2(`SOC_ROM_WORDS);

  addr_t           offset;
  logic [IdxW-1:0] word_idx;
  data_t           rom_word;
  logic            access;
  logic            ack_q;
  logic            err_q;
  data_t           dat_q;

  assign offset   = adr_i - `SOC_ROM_BASE;
  assign word_idx = offset[IdxW+1:2];
  assign access   = cyc_i & stb_i & ~(ack_q | err_q);

  // Boot code table
  always_comb begin
    case (word_idx)
      IdxW'(0): rom_word = 32'h0000_0297;
      IdxW'(1): rom_word = 32'h0202_8593;
      IdxW'(2): rom_word = 32'hF140_2573;
      IdxW'(3): rom_word = 32'h1050_0073;
      default:  rom_word = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= access & ~we_i;
      err_q <= access & we_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_q <= rom_word;
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;
  assign err_o = err_q;

endmodule

`default_nettype wire

// ==== main_ram.sv ====
/*
  Single-port word RAM with byte selects, one-cycle ack.
  Contents are not cleared by reset and start undefined in simulation.
  Address bits above the RAM size are ignored.
*/
`timescale 1ns/100ps
`default_nettype none

`include "soc_config.svh"

module main_ram (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           cyc_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  soc_pkg::sel_t  sel_i,
  input  soc_pkg::addr_t adr_i,
  input  soc_pkg::data_t dat_i,
  output soc_pkg::data_t dat_o,
  output logic           ack_o
);
  import soc_pkg::*;

  localparam int IdxW = $clog2(`SOC_RAM_WORDS);

  data_t           mem_q [`SOC_RAM_WORDS];
  addr_t           offset;
  logic [IdxW-1:0] word_idx;
  logic            access;
  logic            ack_q;
  data_t           dat_q;

  assign offset   = adr_i - `SOC_RAM_BASE;
  assign word_idx = offset[IdxW+1:2];
  assign access   = cyc_i & stb_i & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Array and read port, read returns the word before any write
  always_ff @(posedge clk_i) begin
    if (access) begin
      if (we_i) begin
        for (int b = 0; b < `SOC_SEL_WIDTH; b++) begin
          if (sel_i[b]) begin
            mem_q[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end
      dat_q <= mem_q[word_idx];
    end
  end

  assign dat_o = dat_q;
  assign ack_o = ack_q;

endmodule

`default_nettype wire

// ==== clint.sv ====
/*
  Core-local interruptor for one hart: msip, mtimecmp and mtime.
  rtc_i may be asynchronous to clk_i but must stay high and low for
  at least two clk_i cycles each. Unmapped offsets read zero and ignore writes.
*/
`timescale 1ns/100ps
`default_nettype none

`include "soc_config.svh"

module clint (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           rtc_i,
  input  logic           cyc_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  soc_pkg::sel_t  sel_i,
  input  soc_pkg::addr_t adr_i,
  input  soc_pkg::data_t dat_i,
  output soc_pkg::data_t dat_o,
  output logic           ack_o,
  output logic           timer_irq_o,
  output logic           ipi_o
);
  import soc_pkg::*;

  localparam int DW = `SOC_DATA_WIDTH;

  localparam addr_t MsipOff    = 32'h0000;
  localparam addr_t CmpLoOff   = 32'h4000;
  localparam addr_t CmpHiOff   = 32'h4004;
  localparam addr_t MtimeLoOff = 32'hBFF8;
  localparam addr_t MtimeHiOff = 32'hBFFC;

  addr_t      offset;
  logic       access;
  logic       wr_en;
  logic       ack_q;
  data_t      dat_q;
  logic       msip_q;
  mtime_t     mtime_q;
  mtime_t     mtimecmp_q;
  logic       timer_irq_q;
  logic [2:0] rtc_q;
  logic       rtc_rise;

  // Merge the selected bytes of a write into a register word
  function automatic data_t merge_bytes(data_t old_w, data_t new_w, sel_t sel);
    data_t res;
    res = old_w;
    for (int b = 0; b < `SOC_SEL_WIDTH; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign offset = adr_i - `SOC_CLINT_BASE;
  assign access = cyc_i & stb_i & ~ack_q;
  assign wr_en  = access & we_i;

  // --------------------
  // RTC edge detect
  // --------------------
  // Two sync stages, third flop for the edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q <= '0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
    end
  end

  assign rtc_rise = rtc_q[1] & ~rtc_q[2];

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q       <= 1'b0;
      msip_q      <= 1'b0;
      mtimecmp_q  <= '1;
      mtime_q     <= '0;
      timer_irq_q <= 1'b0;
    end else begin
      ack_q       <= access;
      timer_irq_q <= (mtime_q >= mtimecmp_q);
      if (wr_en && offset == MsipOff && sel_i[0]) begin
        msip_q <= dat_i[0];
      end
      if (wr_en && offset == CmpLoOff) begin
        mtimecmp_q[DW-1:0] <= merge_bytes(mtimecmp_q[DW-1:0], dat_i, sel_i);
      end
      if (wr_en && offset == CmpHiOff) begin
        mtimecmp_q[2*DW-1:DW] <= merge_bytes(mtimecmp_q[2*DW-1:DW], dat_i, sel_i);
      end
      // A bus write to mtime wins over the tick
      if (wr_en && offset == MtimeLoOff) begin
        mtime_q[DW-1:0] <= merge_bytes(mtime_q[DW-1:0], dat_i, sel_i);
      end else if (wr_en && offset == MtimeHiOff) begin
        mtime_q[2*DW-1:DW] <= merge_bytes(mtime_q[2*DW-1:DW], dat_i, sel_i);
      end else if (rtc_rise) begin
        mtime_q <= mtime_q + mtime_t'(1);
      end
    end
  end

  // Read data
  always_ff @(posedge clk_i) begin
    if (access) begin
      case (offset)
        MsipOff:    dat_q <= data_t'(msip_q);
        CmpLoOff:   dat_q <= mtimecmp_q[DW-1:0];
        CmpHiOff:   dat_q <= mtimecmp_q[2*DW-1:DW];
        MtimeLoOff: dat_q <= mtime_q[DW-1:0];
        MtimeHiOff: dat_q <= mtime_q[2*DW-1:DW];
        default:    dat_q <= '0;
      endcase
    end
  end

  assign dat_o       = dat_q;
  assign ack_o       = ack_q;
  assign ipi_o       = msip_q;
  assign timer_irq_o = timer_irq_q;

endmodule

`default_nettype wire

// ==== debug_unit.sv ====
/*
  Debug control: haltreq gating and non-debug system reset.
  The debug request is held off for a fixed window after rst_ni.
  sys_rst_no asserts asynchronously and releases two clocks later.
*/
`timescale 1ns/100ps
`default_nettype none

`include "soc_config.svh"

module debug_unit (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           cyc_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  soc_pkg::addr_t adr_i,
  input  soc_pkg::data_t dat_i,
  output soc_pkg::data_t dat_o,
  output logic           ack_o,
  output logic           debug_req_o,
  output logic           sys_rst_no
);
  import soc_pkg::*;

  localparam int CntW = $clog2(`SOC_DEBUG_DELAY_CYCLES + 1);

  localparam addr_t CtrlOff   = 32'h0;
  localparam addr_t StatusOff = 32'h4;

  addr_t           offset;
  logic            access;
  logic            ack_q;
  data_t           dat_q;
  logic            haltreq_q;
  logic            ndmreset_q;
  logic [CntW-1:0] delay_cnt_q;
  logic            delay_done;
  logic            sys_rst_src_n;
  logic [1:0]      sys_rst_q;

  assign offset = adr_i - `SOC_DEBUG_BASE;
  assign access = cyc_i & stb_i & ~ack_q;

  // --------------------
  // Control registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q      <= 1'b0;
      haltreq_q  <= 1'b0;
      ndmreset_q <= 1'b0;
    end else begin
      ack_q <= access;
      if (access && we_i && offset == CtrlOff) begin
        haltreq_q  <= dat_i[0];
        ndmreset_q <= dat_i[1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      case (offset)
        CtrlOff:   dat_q <= data_t'({ndmreset_q, haltreq_q});
        StatusOff: dat_q <= data_t'(delay_done);
        default:   dat_q <= '0;
      endcase
    end
  end

  // --------------------
  // Debug request gate
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      delay_cnt_q <= CntW'(`SOC_DEBUG_DELAY_CYCLES);
    end else if (!delay_done) begin
      delay_cnt_q <= delay_cnt_q - 1'b1;
    end
  end

  assign delay_done  = (delay_cnt_q == '0);
  assign debug_req_o = haltreq_q & delay_done;

  // --------------------
  // System reset
  // --------------------
  assign sys_rst_src_n = rst_ni & ~ndmreset_q;

  always_ff @(posedge clk_i or negedge sys_rst_src_n) begin
    if (!sys_rst_src_n) begin
      sys_rst_q <= 2'b00;
    end else begin
      sys_rst_q <= {sys_rst_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sys_rst_q[1];
  assign dat_o      = dat_q;
  assign ack_o      = ack_q;

  // No debug request may reach the core inside the boot window
  a_debug_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
    debug_req_o |-> $past(rst_ni, `SOC_DEBUG_DELAY_CYCLES));

endmodule

`default_nettype wire

// ==== soc_top.sv ====
/*
  SoC harness top: one external Wishbone master, four targets.
  Every access completes one cycle after it is presented.
  ROM, RAM and CLINT run on the system reset, which ndmreset also drives.
*/
`timescale 1ns/100ps
`default_nettype none

module soc_top (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           rtc_i,
  input  logic           wb_cyc_i,
  input  logic           wb_stb_i,
  input  logic           wb_we_i,
  input  soc_pkg::sel_t  wb_sel_i,
  input  soc_pkg::addr_t wb_adr_i,
  input  soc_pkg::data_t wb_dat_i,
  output soc_pkg::data_t wb_dat_o,
  output logic           wb_ack_o,
  output logic           wb_err_o,
  output logic           timer_irq_o,
  output logic           ipi_o,
  output logic           debug_req_o,
  output logic           sys_rst_no
);
  import soc_pkg::*;

  logic  dbg_stb, rom_stb, clint_stb, ram_stb;
  logic  dbg_ack, rom_ack, rom_err, clint_ack, ram_ack;
  data_t dbg_dat, rom_dat, clint_dat, ram_dat;

  // --------------------
  // Decoder
  // --------------------
  wb_decoder i_wb_decoder (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .cyc_i       ( wb_cyc_i  ),
    .stb_i       ( wb_stb_i  ),
    .adr_i       ( wb_adr_i  ),
    .dbg_ack_i   ( dbg_ack   ),
    .rom_ack_i   ( rom_ack   ),
    .rom_err_i   ( rom_err   ),
    .clint_ack_i ( clint_ack ),
    .ram_ack_i   ( ram_ack   ),
    .dbg_dat_i   ( dbg_dat   ),
    .rom_dat_i   ( rom_dat   ),
    .clint_dat_i ( clint_dat ),
    .ram_dat_i   ( ram_dat   ),
    .dbg_stb_o   ( dbg_stb   ),
    .rom_stb_o   ( rom_stb   ),
    .clint_stb_o ( clint_stb ),
    .ram_stb_o   ( ram_stb   ),
    .dat_o       ( wb_dat_o  ),
    .ack_o       ( wb_ack_o  ),
    .err_o       ( wb_err_o  )
  );

  // --------------------
  // Reset and debug
  // --------------------
  debug_unit i_debug_unit (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .cyc_i       ( wb_cyc_i    ),
    .stb_i       ( dbg_stb     ),
    .we_i        ( wb_we_i     ),
    .adr_i       ( wb_adr_i    ),
    .dat_i       ( wb_dat_i    ),
    .dat_o       ( dbg_dat     ),
    .ack_o       ( dbg_ack     ),
    .debug_req_o ( debug_req_o ),
    .sys_rst_no  ( sys_rst_no  )
  );

  // --------------------
  // Memories
  // --------------------
  boot_rom i_boot_rom (
    .clk_i  ( clk_i      ),
    .rst_ni ( sys_rst_no ),
    .cyc_i  ( wb_cyc_i   ),
    .stb_i  ( rom_stb    ),
    .we_i   ( wb_we_i    ),
    .adr_i  ( wb_adr_i   ),
    .dat_o  ( rom_dat    ),
    .ack_o  ( rom_ack    ),
    .err_o  ( rom_err    )
  );

  main_ram i_main_ram (
    .clk_i  ( clk_i      ),
    .rst_ni ( sys_rst_no ),
    .cyc_i  ( wb_cyc_i   ),
    .stb_i  ( ram_stb    ),
    .we_i   ( wb_we_i    ),
    .sel_i  ( wb_sel_i   ),
    .adr_i  ( wb_adr_i   ),
    .dat_i  ( wb_dat_i   ),
    .dat_o  ( ram_dat    ),
    .ack_o  ( ram_ack    )
  );

  // --------------------
  // CLINT
  // --------------------
  clint i_clint (
    .clk_i       ( clk_i       ),
    .rst_ni      ( sys_rst_no  ),
    .rtc_i       ( rtc_i       ),
    .cyc_i       ( wb_cyc_i    ),
    .stb_i       ( clint_stb   ),
    .we_i        ( wb_we_i     ),
    .sel_i       ( wb_sel_i    ),
    .adr_i       ( wb_adr_i    ),
    .dat_i       ( wb_dat_i    ),
    .dat_o       ( clint_dat   ),
    .ack_o       ( clint_ack   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // Master sees exactly one kind of termination
  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_ack_o && wb_err_o));

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
/*
  Free-running testbench clock, 100 ns period.
  Starts low at time zero.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // Half period
  always #50 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== tb_soc.sv ====
/*
  Table-driven testbench for the SoC harness.
  All bus accesses go through the single external Wishbone master port.
  RAM data is pseudo-random from a fixed seed, so every run is identical.
*/
`timescale 1ns/100ps
`default_nettype none

`include "soc_config.svh"

module tb_soc;
  import soc_pkg::*;

  typedef enum int {OP_WRITE, OP_READ, OP_ERROR, OP_WAIT, OP_RTC} op_e;

  localparam int BusTimeout  = 20;
  localparam int WaitTimeout = 4 * `SOC_DEBUG_DELAY_CYCLES + 64;
  localparam int SigTimer    = 0;
  localparam int SigIpi      = 1;
  localparam int SigDebug    = 2;
  localparam int SigSysRst   = 3;
  localparam int RamIdx [6]  = '{0, 1, 77, 512, 1000, 1023};

  logic  clk;
  logic  rst_n;
  logic  rtc;
  logic  wb_cyc;
  logic  wb_stb;
  logic  wb_we;
  sel_t  wb_sel;
  addr_t wb_adr;
  data_t wb_dat_w;
  data_t wb_dat_r;
  logic  wb_ack;
  logic  wb_err;
  logic  timer_irq;
  logic  ipi;
  logic  debug_req;
  logic  sys_rst_n;

  // One queue per column of the stimulus table
  string t_name [$];
  op_e   t_op [$];
  logic  t_we [$];
  addr_t t_adr [$];
  data_t t_dat [$];
  sel_t  t_sel [$];
  data_t t_exp [$];

  data_t       ram_model [`SOC_RAM_WORDS];
  logic [31:0] rng_state = 32'h475f_1f27;
  int          n_pass = 0;
  int          n_fail = 0;

  tb_clkgen i_clkgen (.clk_o(clk));

  soc_top dut (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .rtc_i       ( rtc       ),
    .wb_cyc_i    ( wb_cyc    ),
    .wb_stb_i    ( wb_stb    ),
    .wb_we_i     ( wb_we     ),
    .wb_sel_i    ( wb_sel    ),
    .wb_adr_i    ( wb_adr    ),
    .wb_dat_i    ( wb_dat_w  ),
    .wb_dat_o    ( wb_dat_r  ),
    .wb_ack_o    ( wb_ack    ),
    .wb_err_o    ( wb_err    ),
    .timer_irq_o ( timer_irq ),
    .ipi_o       ( ipi       ),
    .debug_req_o ( debug_req ),
    .sys_rst_no  ( sys_rst_n )
  );

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic data_t next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Byte selects widened to a bit mask
  function automatic data_t byte_mask(input sel_t sel);
    data_t m;
    for (int b = 0; b < `SOC_SEL_WIDTH; b++) begin
      m[8*b +: 8] = {8{sel[b]}};
    end
    return m;
  endfunction

  function automatic logic sig_value(input int sig);
    case (sig)
      SigTimer: return timer_irq;
      SigIpi:   return ipi;
      SigDebug: return debug_req;
      default:  return sys_rst_n;
    endcase
  endfunction

  task automatic add_entry(input string name, input op_e op, input logic we,
                           input addr_t adr, input data_t dat, input sel_t sel,
                           input data_t exp);
    t_name.push_back(name);
    t_op.push_back(op);
    t_we.push_back(we);
    t_adr.push_back(adr);
    t_dat.push_back(dat);
    t_sel.push_back(sel);
    t_exp.push_back(exp);
  endtask

  task automatic add_write(input string name, input addr_t adr, input data_t dat);
    add_entry(name, OP_WRITE, 1'b1, adr, dat, 4'hF, '0);
  endtask

  task automatic add_read(input string name, input addr_t adr, input data_t exp);
    add_entry(name, OP_READ, 1'b0, adr, '0, 4'hF, exp);
  endtask

  task automatic add_wait(input string name, input int sig, input logic level);
    add_entry(name, OP_WAIT, 1'b0, addr_t'(sig), '0, '0, data_t'(level));
  endtask

  // RAM accesses also keep the reference model up to date
  task automatic ram_write(input int idx, input data_t dat, input sel_t sel);
    data_t m;
    m = byte_mask(sel);
    add_entry($sformatf("ram write w%0d sel %b", idx, sel), OP_WRITE, 1'b1,
              addr_t'(`SOC_RAM_BASE + idx * 4), dat, sel, '0);
    ram_model[idx] = (ram_model[idx] & ~m) | (dat & m);
  endtask

  task automatic ram_read(input int idx);
    add_read($sformatf("ram read w%0d", idx), addr_t'(`SOC_RAM_BASE + idx * 4),
             ram_model[idx]);
  endtask

  // --------------------
  // Test table
  // --------------------
  task automatic build_table();
    add_wait("sys reset released", SigSysRst, 1'b1);
    add_read("debug status early", `SOC_DEBUG_BASE + 32'h4, 32'h0);
    add_read("rom word 0", `SOC_ROM_BASE + 32'h00, 32'h0000_0297);
    add_read("rom word 1", `SOC_ROM_BASE + 32'h04, 32'h0202_8593);
    add_read("rom word 2", `SOC_ROM_BASE + 32'h08, 32'hF140_2573);
    add_read("rom word 3", `SOC_ROM_BASE + 32'h0C, 32'h1050_0073);
    add_read("rom word 10", `SOC_ROM_BASE + 32'h28, 32'h0);
    add_entry("rom write refused", OP_ERROR, 1'b1, `SOC_ROM_BASE, 32'h1234_5678, 4'hF, '0);
    add_entry("unmapped read", OP_ERROR, 1'b0, 32'h4000_0000, '0, 4'hF, '0);
    foreach (RamIdx[k]) begin
      ram_write(RamIdx[k], next_rand(), 4'hF);
    end
    foreach (RamIdx[k]) begin
      ram_read(RamIdx[k]);
    end
    ram_write(77, next_rand(), 4'b0101);
    ram_read(77);
    ram_write(1000, next_rand(), 4'b1000);
    ram_read(1000);
    // Software interrupt
    add_write("msip set", `SOC_CLINT_BASE, 32'h1);
    add_wait("ipi high", SigIpi, 1'b1);
    add_write("msip clear", `SOC_CLINT_BASE, 32'h0);
    add_wait("ipi low", SigIpi, 1'b0);
    // Timer compare at 3 ticks
    add_write("mtimecmp lo", `SOC_CLINT_BASE + 32'h4000, 32'h3);
    add_write("mtimecmp hi", `SOC_CLINT_BASE + 32'h4004, 32'h0);
    add_wait("timer irq low before ticks", SigTimer, 1'b0);
    add_entry("rtc ticks", OP_RTC, 1'b0, '0, 32'd3, '0, '0);
    add_wait("timer irq high", SigTimer, 1'b1);
    add_read("mtime lo", `SOC_CLINT_BASE + 32'hBFF8, 32'h3);
    // Debug request
    add_write("haltreq set", `SOC_DEBUG_BASE, 32'h1);
    add_wait("debug req high", SigDebug, 1'b1);
    add_read("debug status late", `SOC_DEBUG_BASE + 32'h4, 32'h1);
    add_write("haltreq clear", `SOC_DEBUG_BASE, 32'h0);
    add_wait("debug req low", SigDebug, 1'b0);
    // ndmreset clears the CLINT but not the RAM array
    ram_write(300, next_rand(), 4'hF);
    add_write("msip set before ndm", `SOC_CLINT_BASE, 32'h1);
    add_wait("ipi high before ndm", SigIpi, 1'b1);
    add_write("ndmreset set", `SOC_DEBUG_BASE, 32'h2);
    add_wait("sys reset asserted", SigSysRst, 1'b0);
    add_write("ndmreset clear", `SOC_DEBUG_BASE, 32'h0);
    add_wait("sys reset released again", SigSysRst, 1'b1);
    add_wait("ipi low after ndm", SigIpi, 1'b0);
    add_read("mtimecmp hi after ndm", `SOC_CLINT_BASE + 32'h4004, 32'hFFFF_FFFF);
    ram_read(300);
  endtask

  // --------------------
  // Checks
  // --------------------
  task automatic check_word(input string name, input data_t exp, input data_t act);
    if (act === exp) begin
      n_pass++;
      $display("ok       %s = %h", name, act);
    end else begin
      n_fail++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act === exp) begin
      n_pass++;
      $display("ok       %s = %b", name, act);
    end else begin
      n_fail++;
      $display("** Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // --------------------
  // Bus and signal drivers
  // --------------------
  // Inputs change on the rising edge and outputs are sampled on the falling edge
  task automatic bus_access(input logic w, input addr_t a, input data_t d, input sel_t s,
                            output data_t rdata, output logic got_ack,
                            output logic got_err, output logic done);
    int n;
    rdata   = '0;
    got_ack = 1'b0;
    got_err = 1'b0;
    done    = 1'b0;
    n       = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= w;
    wb_sel   <= s;
    wb_adr   <= a;
    wb_dat_w <= d;
    while (!done && n < BusTimeout) begin
      @(negedge clk);
      n++;
      if (wb_ack || wb_err) begin
        got_ack = wb_ack;
        got_err = wb_err;
        rdata   = wb_dat_r;
        done    = 1'b1;
      end
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wait_signal(input int sig, input logic level, output logic done);
    int n;
    done = 1'b0;
    n    = 0;
    while (!done && n < WaitTimeout) begin
      @(negedge clk);
      n++;
      done = (sig_value(sig) === level);
    end
  endtask

  // Each level lasts several clocks so the synchroniser sees it
  task automatic rtc_pulses(input int count);
    for (int k = 0; k < count; k++) begin
      @(posedge clk);
      rtc <= 1'b1;
      repeat (3) @(posedge clk);
      rtc <= 1'b0;
      repeat (2) @(posedge clk);
    end
  endtask

  task automatic run_entry(input int i);
    data_t rdata;
    logic  got_ack;
    logic  got_err;
    logic  done;
    case (t_op[i])
      OP_WAIT: begin
        wait_signal(int'(t_adr[i]), t_exp[i][0], done);
        if (done) begin
          n_pass++;
          $display("ok       %s = %b", t_name[i], t_exp[i][0]);
        end else begin
          n_fail++;
          $display("%s: signal did not reach %b within %0d cycles",
                   t_name[i], t_exp[i][0], WaitTimeout);
        end
      end
      OP_RTC: begin
        rtc_pulses(int'(t_dat[i]));
        $display("         %s: %0d rtc pulses sent", t_name[i], t_dat[i]);
      end
      default: begin
        bus_access(t_we[i], t_adr[i], t_dat[i], t_sel[i], rdata, got_ack, got_err, done);
        if (!done) begin
          n_fail++;
          $display("%s: no ack or err from the bus within %0d cycles", t_name[i], BusTimeout);
        end else if (t_op[i] == OP_ERROR) begin
          check_bit(t_name[i], 1'b1, got_err);
        end else if (t_op[i] == OP_WRITE) begin
          check_bit(t_name[i], 1'b1, got_ack);
        end else if (!got_ack) begin
          n_fail++;
          $display("%s: read ended with err instead of ack", t_name[i]);
        end else begin
          check_word(t_name[i], t_exp[i], rdata);
        end
      end
    endcase
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    rst_n    = 1'b0;
    rtc      = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_sel   = '0;
    wb_adr   = '0;
    wb_dat_w = '0;
    build_table();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("reset timer_irq", 1'b0, timer_irq);
    check_bit("reset ipi", 1'b0, ipi);
    check_bit("reset debug_req", 1'b0, debug_req);
    for (int i = 0; i < t_name.size(); i++) begin
      run_entry(i);
    end
    $display("Checks: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
soc_pkg.sv
wb_decoder.sv
boot_rom.sv
main_ram.sv
clint.sv
debug_unit.sv
soc_top.sv
tb_clkgen.sv
tb_soc.sv

// ==== Makefile ====
# Verilator build for the SoC harness testbench

VERILATOR ?= verilator
TOP       := tb_soc
RTL_TOP   := soc_top
FILELIST  := project.f
VFLAGS    := --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
